// File: verilog/alu_params.svh
////////////////////////////////////////
// Sizing macros for the integer cluster
// Included by the packages and by the RTL
// that needs a width or a step count
////////////////////////////////////////
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// Operand and result word
`define ALU_DATA_W		32

// Issue number, wraps modulo this width
`define ALU_ISSUE_W		6

`define ALU_DIV_STEPS	`ALU_DATA_W		// One quotient bit per step
`define ALU_WB_ADDR_W	3				// Host word address

`endif

// File: verilog/pkg_tpu.sv
////////////////////////////////////////
// Execution path types of the cluster
// Operand words, issue numbers and the
// token that rides along with a command
////////////////////////////////////////
`include "alu_params.svh"

package pkg_tpu;

	typedef logic [`ALU_DATA_W-1:0]		data_t;
	typedef logic [`ALU_ISSUE_W-1:0]	issue_no_t;

	// Operation classes
	typedef enum logic [2:0] {
		op_add	= 3'd0,
		op_sub	= 3'd1,
		op_mul	= 3'd2,
		op_madd	= 3'd3,
		op_div	= 3'd4
	} op_class_t;

	// Low byte of the command register
	typedef struct packed {
		logic [3:0]	rsvd;
		logic		sub_op;		// Remainder select on divide
		op_class_t	op_class;
	} op_t;

	typedef struct packed {
		op_t		op;
		issue_no_t	issue_no;	// Stamped at issue
	} pipe_exe_tmp_t;

endpackage

// File: verilog/pkg_wb.sv
////////////////////////////////////////
// Host bus view of the cluster
// Register map and STATUS word layout
////////////////////////////////////////
`include "alu_params.svh"

package pkg_wb;

	typedef enum logic [`ALU_WB_ADDR_W-1:0] {
		reg_src1	= 3'd0,
		reg_src2	= 3'd1,
		reg_src3	= 3'd2,
		reg_cmd		= 3'd3,		// Write issues the command
		reg_result	= 3'd4,		// Read frees the result slot
		reg_status	= 3'd5
	} reg_addr_t;

	typedef struct packed {
		logic [`ALU_DATA_W-`ALU_ISSUE_W-9:0]	rsvd_hi;
		logic [`ALU_ISSUE_W-1:0]				issue_no;	// Bits 13:8
		logic [4:0]								rsvd_lo;
		logic									busy_div;
		logic									busy_ma;
		logic									result_valid;
	} status_t;

endpackage

// File: verilog/exe_if.sv
////////////////////////////////////////
// Link between the ALU and one execution
// unit. Carries the command in and the
// finished result back out
////////////////////////////////////////
`timescale 1ns/1ps

interface exe_if #(
	parameter type TYPE = pkg_tpu::pipe_exe_tmp_t
) ();

	// Command group
	logic				en;
	pkg_tpu::data_t		data1;
	pkg_tpu::data_t		data2;
	pkg_tpu::data_t		data3;
	TYPE				token;

	logic				ready;		// Unit can accept this clock

	// Result group, held while valid
	logic				valid;
	pkg_tpu::data_t		data;
	TYPE				token_out;
	logic				take;		// ALU writes the result back

	modport alu (output en, data1, data2, data3, token, take,
		input ready, valid, data, token_out);
	modport unit (input en, data1, data2, data3, token, take,
		output ready, valid, data, token_out);

endinterface

// File: verilog/ma_unit.sv
////////////////////////////////////////
// Multiply-add unit, three stages deep
// Add, sub, mul and madd with the token
// carried next to each stage. Stalls as a
// whole when the last stage is not taken
////////////////////////////////////////
`timescale 1ns/1ps

module ma_unit #(
	parameter type TYPE = pkg_tpu::pipe_exe_tmp_t
)(
	input			clock,
	input			rst_n,
	exe_if.unit		exe
);

	logic				v1, v2, v3;
	TYPE				tok1, tok2, tok3;
	pkg_tpu::data_t		a1, b1, c1;
	pkg_tpu::data_t		r2, c2;
	pkg_tpu::data_t		r3;
	logic				stall;

	assign stall		= v3 & ~exe.take;	// Oldest result still held
	assign exe.ready	= ~stall;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			v3 <= 1'b0;
		end else if (!stall) begin
			v1 <= exe.en;
			v2 <= v1;
			v3 <= v2;
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			// Stage 1, operand capture
			tok1 <= exe.token;
			a1 <= exe.data1;
			b1 <= exe.data2;
			c1 <= exe.data3;
			// Stage 2, sum or product
			tok2 <= tok1;
			c2 <= c1;
			case (tok1.op.op_class)
				pkg_tpu::op_add:	r2 <= a1 + b1;
				pkg_tpu::op_sub:	r2 <= a1 - b1;
				default:			r2 <= a1 * b1;	// Low word only
			endcase
			// Stage 3, accumulate for madd
			tok3 <= tok2;
			r3 <= (tok2.op.op_class == pkg_tpu::op_madd) ? r2 + c2 : r2;
		end
	end

	assign exe.valid		= v3;
	assign exe.data			= r3;
	assign exe.token_out	= tok3;

endmodule

// File: verilog/idiv_step_counter.sv
////////////////////////////////////////
// Iteration counter of the divider
// Loads on start, counts down per step
////////////////////////////////////////
`timescale 1ns/1ps
`include "alu_params.svh"

module idiv_step_counter (
	input		clock,
	input		rst_n,
	input		start,
	input		step,
	output		last
);

	localparam int CNT_W = $clog2(`ALU_DIV_STEPS);

	logic [CNT_W-1:0]	cnt;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			cnt <= '0;
		else if (start)
			cnt <= CNT_W'(`ALU_DIV_STEPS - 1);
		else if (step && cnt != '0)
			cnt <= cnt - 1'b1;
	end

	assign last = step & (cnt == '0);		// Final iteration

endmodule

// File: verilog/idiv_unit.sv
////////////////////////////////////////
// Iterative integer divider
// Restoring shift-subtract, one quotient
// bit per clock. Result is held until the
// ALU takes it, quotient or remainder
// picked by the token's sub-op bit
////////////////////////////////////////
`timescale 1ns/1ps

module idiv_unit #(
	parameter type TYPE = pkg_tpu::pipe_exe_tmp_t
)(
	input			clock,
	input			rst_n,
	exe_if.unit		exe
);

	localparam int W = $bits(pkg_tpu::data_t);

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_hold
	} state_t;

	state_t				state;
	logic				start, step, last;
	pkg_tpu::data_t		rem, quot, dvsr;
	TYPE				tok;
	logic [W:0]			shifted;
	logic [W:0]			diff;

	assign exe.ready	= (state == st_idle);
	assign start		= exe.en & exe.ready;
	assign step			= (state == st_run);

	//////////////////////////////////////
	// Control
	//////////////////////////////////////
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			state <= st_idle;
		else begin
			case (state)
				st_idle:	if (start) state <= st_run;
				st_run:		if (last) state <= st_hold;
				st_hold:	if (exe.take) state <= st_idle;
				default:	state <= st_idle;
			endcase
		end
	end

	idiv_step_counter u_cnt (
		.clock	(clock),
		.rst_n	(rst_n),
		.start	(start),
		.step	(step),
		.last	(last)
	);

	//////////////////////////////////////
	// Datapath
	//////////////////////////////////////
	assign shifted	= {rem, quot[W-1]};
	assign diff		= shifted - {1'b0, dvsr};

	always_ff @(posedge clock) begin
		if (start) begin
			rem <= '0;
			quot <= exe.data1;		// Dividend shifts out as quotient shifts in
			dvsr <= exe.data2;
			tok <= exe.token;
		end else if (step) begin
			if (shifted >= {1'b0, dvsr}) begin
				rem <= diff[W-1:0];
				quot <= {quot[W-2:0], 1'b1};
			end else begin
				rem <= shifted[W-1:0];
				quot <= {quot[W-2:0], 1'b0};
			end
		end
	end

	// A zero divisor subtracts nothing on every step, so the quotient
	// fills with ones and rem ends up as the dividend
	assign exe.valid		= (state == st_hold);
	assign exe.data			= tok.op.sub_op ? rem : quot;
	assign exe.token_out	= tok;

endmodule

// File: verilog/alu.sv
////////////////////////////////////////
// ALU dispatch of the integer cluster
// Steers each command to the multiply-add
// or the divide unit, then hands the oldest
// finished result to write-back
////////////////////////////////////////
`timescale 1ns/1ps

module alu #(
	parameter type TYPE = pkg_tpu::pipe_exe_tmp_t
)(
	input						clock,
	input						rst_n,
	input	pkg_tpu::issue_no_t	issue_no,		// Current issue number
	input						req,
	input	TYPE				command,
	input	pkg_tpu::data_t		src_data1,
	input	pkg_tpu::data_t		src_data2,
	input	pkg_tpu::data_t		src_data3,
	output						accept,
	input						slot_free,
	output	TYPE				wb_token,
	output	pkg_tpu::data_t		wb_data,
	output						alu_done
);

	exe_if #(.TYPE(TYPE)) ma_if ();
	exe_if #(.TYPE(TYPE)) div_if ();

	logic					is_div;
	logic					en_ma, en_div;
	pkg_tpu::issue_no_t		life_ma, life_div;
	logic					sel_div;

	//////////////////////////////////////
	// Issue side
	//////////////////////////////////////
	assign is_div	= (command.op.op_class == pkg_tpu::op_div);
	assign en_ma	= req & ~is_div;	// Every other class runs on MA
	assign en_div	= req & is_div;
	assign accept	= (en_ma & ma_if.ready) | (en_div & div_if.ready);

	assign ma_if.en		= en_ma;
	assign ma_if.data1	= en_ma ? src_data1 : '0;
	assign ma_if.data2	= en_ma ? src_data2 : '0;
	assign ma_if.data3	= en_ma ? src_data3 : '0;
	assign ma_if.token	= en_ma ? command : '0;

	assign div_if.en	= en_div;
	assign div_if.data1	= en_div ? src_data1 : '0;	// Dividend
	assign div_if.data2	= en_div ? src_data2 : '0;	// Divisor
	assign div_if.data3	= '0;
	assign div_if.token	= en_div ? command : '0;

	//////////////////////////////////////
	// Write-back side
	//////////////////////////////////////
	// Age modulo the issue width
	assign life_ma	= issue_no - ma_if.token_out.issue_no;
	assign life_div	= issue_no - div_if.token_out.issue_no;

	assign sel_div	= div_if.valid & (~ma_if.valid | (life_div > life_ma));
	assign alu_done	= (ma_if.valid | div_if.valid) & slot_free;

	assign ma_if.take	= alu_done & ~sel_div;
	assign div_if.take	= alu_done & sel_div;

	assign wb_token	= sel_div ? div_if.token_out : ma_if.token_out;
	assign wb_data	= sel_div ? div_if.data : ma_if.data;

	ma_unit #(.TYPE(TYPE)) u_ma (
		.clock	(clock),
		.rst_n	(rst_n),
		.exe	(ma_if.unit)
	);

	idiv_unit #(.TYPE(TYPE)) u_div (
		.clock	(clock),
		.rst_n	(rst_n),
		.exe	(div_if.unit)
	);

endmodule

// File: verilog/alu_wb_top.sv
////////////////////////////////////////
// Top of the integer cluster
// Wishbone classic slave with source and
// command registers, the issue counter and
// a single result slot the host reads back
////////////////////////////////////////
`timescale 1ns/1ps
`include "alu_params.svh"

module alu_wb_top (
	input								clock,
	input								rst_n,
	input								wb_cyc,
	input								wb_stb,
	input								wb_we,
	input	[`ALU_WB_ADDR_W-1:0]		wb_adr,
	input	pkg_tpu::data_t				wb_dat_w,
	output	pkg_tpu::data_t				wb_dat_r,
	output								wb_ack
);

	logic						pend;			// Strobe seen last clock
	logic						cmd_wr, res_rd, cmd_acc, cmd_is_div;
	logic						req, accept, alu_done, wb_is_div;
	pkg_tpu::data_t				src1, src2, src3;
	pkg_tpu::issue_no_t			issue_cnt;
	pkg_tpu::pipe_exe_tmp_t		cmd_token, wb_token;
	pkg_tpu::data_t				wb_data;
	logic						res_valid;
	pkg_tpu::data_t				res_data;
	pkg_tpu::issue_no_t			res_issue;
	logic [1:0]					ma_cnt;			// MA ops in flight
	logic						div_busy;
	pkg_wb::status_t			status;

	assign cmd_wr	= wb_we & (wb_adr == pkg_wb::reg_cmd);
	assign req		= pend & wb_cyc & wb_stb & cmd_wr;
	assign wb_ack	= pend & wb_cyc & wb_stb & (~cmd_wr | accept);	// CMD waits on unit
	assign cmd_acc	= wb_ack & cmd_wr;
	assign res_rd	= wb_ack & ~wb_we & (wb_adr == pkg_wb::reg_result);

	always_comb begin
		cmd_token.op = pkg_tpu::op_t'(wb_dat_w[7:0]);
		cmd_token.issue_no = issue_cnt;
	end

	assign cmd_is_div	= (cmd_token.op.op_class == pkg_tpu::op_div);
	assign wb_is_div	= (wb_token.op.op_class == pkg_tpu::op_div);

	//////////////////////////////////////
	// Control state
	//////////////////////////////////////
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			pend <= 1'b0;
			issue_cnt <= '0;
			res_valid <= 1'b0;
			res_data <= '0;
			res_issue <= '0;
			ma_cnt <= '0;
			div_busy <= 1'b0;
		end else begin
			pend <= wb_ack ? 1'b0 : (wb_cyc & wb_stb);
			if (cmd_acc)
				issue_cnt <= issue_cnt + 1'b1;
			// Load and release never overlap
			if (alu_done) begin
				res_valid <= 1'b1;
				res_data <= wb_data;
				res_issue <= wb_token.issue_no;
			end else if (res_rd)
				res_valid <= 1'b0;
			case ({cmd_acc & ~cmd_is_div, alu_done & ~wb_is_div})
				2'b10:		ma_cnt <= ma_cnt + 1'b1;
				2'b01:		ma_cnt <= ma_cnt - 1'b1;
				default:	ma_cnt <= ma_cnt;
			endcase
			if (cmd_acc && cmd_is_div)
				div_busy <= 1'b1;
			else if (alu_done && wb_is_div)
				div_busy <= 1'b0;
		end
	end

	// Source operands
	always_ff @(posedge clock) begin
		if (wb_ack && wb_we) begin
			case (pkg_wb::reg_addr_t'(wb_adr))
				pkg_wb::reg_src1:	src1 <= wb_dat_w;
				pkg_wb::reg_src2:	src2 <= wb_dat_w;
				pkg_wb::reg_src3:	src3 <= wb_dat_w;
				default:			;
			endcase
		end
	end

	//////////////////////////////////////
	// Read back
	//////////////////////////////////////
	always_comb begin
		status = '0;
		status.result_valid = res_valid;
		status.busy_ma = (ma_cnt != '0);
		status.busy_div = div_busy;
		status.issue_no = res_issue;
		case (pkg_wb::reg_addr_t'(wb_adr))
			pkg_wb::reg_src1:	wb_dat_r = src1;
			pkg_wb::reg_src2:	wb_dat_r = src2;
			pkg_wb::reg_src3:	wb_dat_r = src3;
			pkg_wb::reg_result:	wb_dat_r = res_data;
			pkg_wb::reg_status:	wb_dat_r = status;
			default:			wb_dat_r = '0;
		endcase
	end

	alu #(.TYPE(pkg_tpu::pipe_exe_tmp_t)) u_alu (
		.clock		(clock),
		.rst_n		(rst_n),
		.issue_no	(issue_cnt),
		.req		(req),
		.command	(cmd_token),
		.src_data1	(src1),
		.src_data2	(src2),
		.src_data3	(src3),
		.accept		(accept),
		.slot_free	(~res_valid),
		.wb_token	(wb_token),
		.wb_data	(wb_data),
		.alu_done	(alu_done)
	);

endmodule

// File: dv/alu_checker.sv
////////////////////////////////////////
// Result checker of the cluster testbench
// Snoops the Wishbone port, keeps the
// operands of every issued command and
// compares each RESULT read in order
////////////////////////////////////////
`timescale 1ns/1ps
`include "alu_params.svh"

module alu_checker (
	input							clock,
	input							wb_cyc,
	input							wb_stb,
	input							wb_we,
	input	[`ALU_WB_ADDR_W-1:0]	wb_adr,
	input	pkg_tpu::data_t			wb_dat_w,
	input	pkg_tpu::data_t			wb_dat_r,
	input							wb_ack,
	input							exp_load,
	input	[7:0]					exp_id,
	input							exp_rule,		// Value from the op rule
	input	pkg_tpu::issue_no_t		exp_issue,
	input	pkg_tpu::data_t			exp_data,
	output	int						checks,
	output	int						errors,
	output	int						pending
);

	localparam int N_ISSUE = 1 << `ALU_ISSUE_W;

	typedef struct packed {
		logic [7:0]				id;
		logic					rule;
		pkg_tpu::issue_no_t		issue;
		pkg_tpu::data_t			data;
	} expect_t;

	expect_t				exp_q[$];		// In expected read order
	logic [3:0]				op_tab [0:N_ISSUE-1];
	pkg_tpu::data_t			a_tab [0:N_ISSUE-1];
	pkg_tpu::data_t			b_tab [0:N_ISSUE-1];
	pkg_tpu::data_t			c_tab [0:N_ISSUE-1];
	pkg_tpu::data_t			src1, src2, src3;
	pkg_tpu::issue_no_t		cmd_cnt = '0;
	pkg_wb::status_t		last_status = '0;
	logic					status_seen = 1'b0;
	logic					empty_read = 1'b0;
	int						n_checks = 0;
	int						n_errors = 0;
	int						n_pending = 0;

	assign checks	= n_checks;
	assign errors	= n_errors;
	assign pending	= n_pending;

	function automatic pkg_tpu::data_t rule_value(input logic [3:0] op,
		input pkg_tpu::data_t a, input pkg_tpu::data_t b, input pkg_tpu::data_t c);
		case (op[2:0])
			pkg_tpu::op_add:	rule_value = a + b;
			pkg_tpu::op_sub:	rule_value = a - b;
			pkg_tpu::op_mul:	rule_value = a * b;		// Low word
			pkg_tpu::op_madd:	rule_value = a * b + c;
			default: begin
				if (b == '0)
					rule_value = op[3] ? a : '1;
				else
					rule_value = op[3] ? a % b : a / b;
			end
		endcase
	endfunction

	function automatic string op_name(input logic [3:0] op);
		case (op[2:0])
			pkg_tpu::op_add:	op_name = "add";
			pkg_tpu::op_sub:	op_name = "sub";
			pkg_tpu::op_mul:	op_name = "mul";
			pkg_tpu::op_madd:	op_name = "madd";
			default:			op_name = op[3] ? "div_r" : "div_q";
		endcase
	endfunction

	task automatic report(input string name, input pkg_tpu::data_t want,
		input pkg_tpu::data_t got);
		n_checks++;
		if (got === want)
			$display("Pass  %s: %h", name, got);
		else begin
			n_errors++;
			$display("Error %s: expected %h, actual %h", name, want, got);
		end
	endtask

	//////////////////////////////////////
	// Bus snooping
	//////////////////////////////////////
	task automatic snoop_write();
		case (wb_adr)
			pkg_wb::reg_src1:	src1 = wb_dat_w;
			pkg_wb::reg_src2:	src2 = wb_dat_w;
			pkg_wb::reg_src3:	src3 = wb_dat_w;
			pkg_wb::reg_cmd: begin
				op_tab[cmd_cnt] = wb_dat_w[3:0];		// Class and sub-op
				a_tab[cmd_cnt] = src1;
				b_tab[cmd_cnt] = src2;
				c_tab[cmd_cnt] = src3;
				cmd_cnt = cmd_cnt + 1'b1;
			end
			default:	;
		endcase
	endtask

	task automatic check_status(input pkg_wb::status_t st);
		if (!status_seen)
			report("reset status", '0, st);
		else if (empty_read)
			report("status after empty RESULT read", last_status, st);
		status_seen = 1'b1;
		empty_read = 1'b0;
		last_status = st;
	endtask

	task automatic check_result(input pkg_tpu::data_t data);
		expect_t			e;
		pkg_tpu::data_t		want;
		string				name;
		if (!last_status.result_valid) begin
			empty_read = 1'b1;		// STATUS must not move
		end else if (exp_q.size() == 0) begin
			n_errors++;
			$display("Result of issue %0d was read but no result was expected",
				last_status.issue_no);
		end else begin
			e = exp_q.pop_front();
			name = $sformatf("test %0d %s", e.id, op_name(op_tab[e.issue]));
			if (e.rule)
				want = rule_value(op_tab[e.issue], a_tab[e.issue], b_tab[e.issue],
					c_tab[e.issue]);
			else
				want = e.data;
			if (last_status.issue_no != e.issue) begin
				n_checks++;
				n_errors++;
				$display("Error %s: expected issue %0d, actual issue %0d", name, e.issue,
					last_status.issue_no);
			end else
				report(name, want, data);
		end
	endtask

	always @(posedge clock) begin
		if (exp_load)
			exp_q.push_back({exp_id, exp_rule, exp_issue, exp_data});
		if (wb_cyc && wb_stb && wb_ack) begin
			if (wb_we)
				snoop_write();
			else if (wb_adr == pkg_wb::reg_status)
				check_status(wb_dat_r);
			else if (wb_adr == pkg_wb::reg_result)
				check_result(wb_dat_r);
		end
		n_pending = exp_q.size();
	end

endmodule

// File: dv/tb_alu.sv
////////////////////////////////////////
// Testbench top of the integer cluster
// Runs the golden table over the Wishbone
// port and tells the checker which result
// to expect next
////////////////////////////////////////
`timescale 1ns/1ps
`include "alu_params.svh"

module tb_alu;

	localparam int MAX_LINES	= 32;
	localparam int COLS			= 8;		// Words per golden line
	localparam int TIMEOUT		= 200;

	logic						clock;
	logic						rst_n;
	logic						wb_cyc, wb_stb, wb_we;
	logic [`ALU_WB_ADDR_W-1:0]	wb_adr;
	pkg_tpu::data_t				wb_dat_w, wb_dat_r;
	logic						wb_ack;

	logic						exp_load;
	logic [7:0]					exp_id;
	logic						exp_rule;
	pkg_tpu::issue_no_t			exp_issue;
	pkg_tpu::data_t				exp_data;
	int							checks, errors, pending;

	logic [31:0]				golden [0:MAX_LINES*COLS-1];
	pkg_tpu::issue_no_t			issue;		// Counts CMD acks from zero
	integer						seed;
	int							tb_errors;
	int							cycle_cnt = 0;

	initial clock = 1'b0;
	always #20 clock = ~clock;
	always @(posedge clock) cycle_cnt <= cycle_cnt + 1;

	//////////////////////////////////////
	// Wishbone driver
	//////////////////////////////////////
	task automatic bus_cycle(input logic we, input logic [`ALU_WB_ADDR_W-1:0] adr,
		input pkg_tpu::data_t wdata, output pkg_tpu::data_t rdata, output logic acked);
		int waited;
		@(negedge clock);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdata;
		waited = 0;
		@(negedge clock);
		while (!wb_ack && waited < TIMEOUT) begin
			@(negedge clock);
			waited++;
		end
		acked = wb_ack;
		rdata = wb_dat_r;
		if (!acked) begin
			$display("Bus cycle to address %0d got no ack within %0d cycles", adr, TIMEOUT);
			tb_errors++;
		end
		@(negedge clock);		// Ack clock lies in between
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic write_reg(input logic [`ALU_WB_ADDR_W-1:0] adr, input pkg_tpu::data_t d);
		pkg_tpu::data_t	unused;
		logic			acked;
		bus_cycle(1'b1, adr, d, unused, acked);
	endtask

	task automatic read_reg(input logic [`ALU_WB_ADDR_W-1:0] adr, output pkg_tpu::data_t d);
		logic acked;
		bus_cycle(1'b0, adr, '0, d, acked);
	endtask

	task automatic issue_cmd(input logic [2:0] op, input logic sub,
		output pkg_tpu::issue_no_t num);
		pkg_tpu::data_t	unused;
		logic			acked;
		num = issue;
		bus_cycle(1'b1, pkg_wb::reg_cmd, {28'd0, sub, op}, unused, acked);
		if (acked)
			issue = issue + 1'b1;
	endtask

	// Queues one expectation in the checker, in read order
	task automatic expect_result(input pkg_tpu::issue_no_t num, input logic rule,
		input pkg_tpu::data_t d, input logic [7:0] id);
		@(negedge clock);
		exp_load = 1'b1;
		exp_issue = num;
		exp_rule = rule;
		exp_data = d;
		exp_id = id;
		@(negedge clock);
		exp_load = 1'b0;
	endtask

	task automatic wait_result(output logic valid);
		pkg_wb::status_t	st;
		logic				acked;
		int					start;
		start = cycle_cnt;
		st = '0;
		while (!st.result_valid && cycle_cnt - start < TIMEOUT)
			bus_cycle(1'b0, pkg_wb::reg_status, '0, st, acked);
		valid = st.result_valid;
		if (!valid) begin
			$display("No result became valid within %0d cycles", TIMEOUT);
			tb_errors++;
		end
	endtask

	task automatic collect_results(input int count);
		pkg_tpu::data_t	word;
		logic			valid;
		repeat (count) begin
			wait_result(valid);
			if (valid)
				read_reg(pkg_wb::reg_result, word);
		end
	endtask

	task automatic run_line(input int base);
		logic [7:0]				id, mode;
		logic [2:0]				op;
		logic					sub;
		pkg_tpu::data_t			s1, s2, s3;
		pkg_tpu::issue_no_t		first, second;
		id = golden[base][7:0];
		op = golden[base+1][2:0];
		sub = golden[base+2][0];
		s1 = golden[base+3];
		s2 = golden[base+4];
		s3 = golden[base+5];
		mode = golden[base+7][7:0];
		if (mode == 8'd2) begin
			s1 = $random(seed);
			s2 = $random(seed);
			s3 = $random(seed);
		end
		write_reg(pkg_wb::reg_src1, s1);
		write_reg(pkg_wb::reg_src2, s2);
		write_reg(pkg_wb::reg_src3, s3);
		issue_cmd(op, sub, first);
		case (mode)
			8'd1: begin
				issue_cmd(pkg_tpu::op_add, 1'b0, second);
				expect_result(second, 1'b1, '0, id);		// Add overtakes the divide
				expect_result(first, 1'b0, golden[base+6], id);
				collect_results(2);
			end
			8'd3: begin
				issue_cmd(pkg_tpu::op_div, 1'b1, second);	// Held until first is done
				expect_result(first, 1'b0, golden[base+6], id);
				expect_result(second, 1'b1, '0, id);
				collect_results(2);
			end
			default: begin
				expect_result(first, mode == 8'd2, golden[base+6], id);
				collect_results(1);
			end
		endcase
	endtask

	//////////////////////////////////////
	// DUT and checker
	//////////////////////////////////////
	alu_wb_top DUT (
		.clock		(clock),
		.rst_n		(rst_n),
		.wb_cyc		(wb_cyc),
		.wb_stb		(wb_stb),
		.wb_we		(wb_we),
		.wb_adr		(wb_adr),
		.wb_dat_w	(wb_dat_w),
		.wb_dat_r	(wb_dat_r),
		.wb_ack		(wb_ack)
	);

	alu_checker result_check (
		.clock		(clock),
		.wb_cyc		(wb_cyc),
		.wb_stb		(wb_stb),
		.wb_we		(wb_we),
		.wb_adr		(wb_adr),
		.wb_dat_w	(wb_dat_w),
		.wb_dat_r	(wb_dat_r),
		.wb_ack		(wb_ack),
		.exp_load	(exp_load),
		.exp_id		(exp_id),
		.exp_rule	(exp_rule),
		.exp_issue	(exp_issue),
		.exp_data	(exp_data),
		.checks		(checks),
		.errors		(errors),
		.pending	(pending)
	);

	initial begin : main
		pkg_tpu::data_t	word;
		int				line;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		exp_load = 1'b0;
		exp_id = '0;
		exp_rule = 1'b0;
		exp_issue = '0;
		exp_data = '0;
		issue = '0;
		tb_errors = 0;
		seed = 32'h619e_e6c9;
		rst_n = 1'b0;
		$readmemh("dv/alu_golden.hex", golden);
		repeat (16) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;

		// Idle STATUS, then a RESULT read with nothing held
		read_reg(pkg_wb::reg_status, word);
		read_reg(pkg_wb::reg_result, word);
		read_reg(pkg_wb::reg_status, word);

		line = 0;
		while (line < MAX_LINES && golden[line*COLS] != 32'hff) begin
			run_line(line * COLS);
			line++;
		end
		repeat (4) @(negedge clock);

		if (pending != 0) begin
			$display("%0d expected results were never read back", pending);
			tb_errors++;
		end
		$display("Checks: %0d, errors: %0d", checks, errors + tb_errors);
		if (errors + tb_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: sources.f
+incdir+verilog
verilog/pkg_tpu.sv
verilog/pkg_wb.sv
verilog/exe_if.sv
verilog/ma_unit.sv
verilog/idiv_step_counter.sv
verilog/idiv_unit.sv
verilog/alu.sv
verilog/alu_wb_top.sv
dv/alu_checker.sv
dv/tb_alu.sv

// File: run_sim.sh
#!/bin/sh
# Builds the cluster testbench with Verilator, runs it and
# decides pass or fail from the simulation log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f sources.f --top-module tb_alu --Mdir obj_dir -o tb_alu_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_alu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: dv/alu_golden.hex
// id op sub src1 src2 src3 expected mode, all hex
// mode 0 single, 1 divide then add, 2 random operands, 3 back-to-back divides
01 0 0 00000005 00000007 00000000 0000000c 0
02 0 0 ffffffff 00000002 00000000 00000001 0
03 1 0 00000010 00000003 00000000 0000000d 0
04 1 0 00000003 00000005 00000000 fffffffe 0
05 2 0 00001234 00000100 00000000 00123400 0
06 2 0 80000001 00000003 00000000 80000003 0
07 3 0 00000006 00000007 00000008 00000032 0
08 3 0 ffffffff ffffffff 00000005 00000006 0
09 3 0 00000000 00000000 00000000 00000000 2
0a 3 0 00000000 00000000 00000000 00000000 2
0b 4 0 00000064 00000007 00000000 0000000e 0
0c 4 1 00000064 00000007 00000000 00000002 0
0d 4 0 00000003 00000009 00000000 00000000 0
0e 4 1 00000003 00000009 00000000 00000003 0
0f 4 0 ffffffff 00000010 00000000 0fffffff 0
10 4 1 ffffffff 00000010 00000000 0000000f 0
11 4 0 ffffffff ffffffff 00000000 00000001 0
12 4 0 00001234 00000000 00000000 ffffffff 0
13 4 1 00001234 00000000 00000000 00001234 0
14 4 0 000003e8 00000019 00000000 00000028 1
15 4 0 0000abcd 00000012 00000000 0000098b 3
ff 0 0 00000000 00000000 00000000 00000000 0
